// File: hw/icache_defs.svh
// Instruction-cache bank geometry: set count, line size, word and address widths

`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// Number of direct-mapped sets in the bank
`define ICB_SETS 16

// Words held by one cache line
`define ICB_LINE_WORDS 4

// Width of one instruction word in bits
`define ICB_WORD_W 32

// Width of the byte address presented on lookup and fill
`define ICB_ADDR_W 32

// Full line width, handy for the data RAM
`define ICB_LINE_W (`ICB_LINE_WORDS * `ICB_WORD_W)

`endif

// File: hw/icache_pkg.sv
// Instruction-cache package with address field widths, RAM modes and request/response structs

`include "icache_defs.svh"

package icache_pkg;

    // Byte offset inside a word
    localparam int offset_w = $clog2(`ICB_WORD_W / 8);

    // Word select inside a line
    localparam int word_sel_w = $clog2(`ICB_LINE_WORDS);

    // Set index
    localparam int index_w = $clog2(`ICB_SETS);

    // Everything above the index is tag
    localparam int tag_w = `ICB_ADDR_W - index_w - word_sel_w - offset_w;

    // Read-during-write behavior of the single-port RAM
    typedef enum logic [1:0] {
        read_first,
        write_first,
        no_change
    } ram_mode_e;

    typedef struct packed {
        logic                   valid;
        logic [`ICB_ADDR_W-1:0] addr;
    } lookup_req_t;

    // One refill word; first and last bracket the line
    typedef struct packed {
        logic                   valid;
        logic [`ICB_ADDR_W-1:0] addr;
        logic [`ICB_WORD_W-1:0] data;
        logic                   first;
        logic                   last;
    } fill_req_t;

    // Data is only meaningful when hit is set
    typedef struct packed {
        logic                   valid;
        logic                   hit;
        logic [`ICB_WORD_W-1:0] data;
    } lookup_rsp_t;

endpackage

// File: hw/sp_ram.sv
// Single-port RAM with per-lane write enables, registered read and selectable read-during-write

`timescale 1ns/1ps

module sp_ram #(
    parameter int                    DATAW = 32,
    parameter int                    SIZE  = 16,
    parameter int                    WRENW = 1,
    parameter icache_pkg::ram_mode_e MODE  = icache_pkg::read_first,
    parameter int                    ADDRW = (SIZE > 1) ? $clog2(SIZE) : 1
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             read,
    input  logic             write,
    input  logic [WRENW-1:0] wren,
    input  logic [ADDRW-1:0] addr,
    input  logic [DATAW-1:0] wdata,
    output logic [DATAW-1:0] rdata
);

    // Each write-enable bit covers one lane of this width
    localparam int LANEW = DATAW / WRENW;

    logic [DATAW-1:0] mem [SIZE];

    logic [DATAW-1:0] cur_word;
    logic [DATAW-1:0] new_word;
    logic [DATAW-1:0] rdata_q;

    assign cur_word = mem[addr];

    // Contents of the addressed entry as they will be after this edge
    always_comb begin
        new_word = cur_word;
        for (int i = 0; i < WRENW; i++) begin
            if (write && wren[i]) begin
                new_word[i*LANEW +: LANEW] = wdata[i*LANEW +: LANEW];
            end
        end
    end

    // Lane-wise write so only enabled lanes of the entry change
    always_ff @(posedge clk) begin
        if (write) begin
            for (int i = 0; i < WRENW; i++) begin
                if (wren[i]) begin
                    mem[addr][i*LANEW +: LANEW] <= wdata[i*LANEW +: LANEW];
                end
            end
        end
    end

    generate
        if (MODE == icache_pkg::read_first) begin : g_read_first
            // A write still returns what was there before it
            always_ff @(posedge clk) begin
                if (reset) begin
                    rdata_q <= '0;
                end else if (read || write) begin
                    rdata_q <= cur_word;
                end
            end
        end else if (MODE == icache_pkg::write_first) begin : g_write_first
            // A write forwards the merged new contents
            always_ff @(posedge clk) begin
                if (reset) begin
                    rdata_q <= '0;
                end else if (read || write) begin
                    rdata_q <= new_word;
                end
            end
        end else begin : g_no_change
            // Output holds its last read value through writes
            always_ff @(posedge clk) begin
                if (reset) begin
                    rdata_q <= '0;
                end else if (read && !write) begin
                    rdata_q <= cur_word;
                end
            end
        end
    endgenerate

    assign rdata = rdata_q;

endmodule

// File: hw/icache_tag_store.sv
// Instruction-cache tag store: tag RAM, per-set valid bits and registered hit compare

`timescale 1ns/1ps

`include "icache_defs.svh"

module icache_tag_store (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           read,
    input  logic [icache_pkg::index_w-1:0] index,
    input  logic [icache_pkg::tag_w-1:0]   lookup_tag,
    input  logic                           write,
    input  logic                           first,
    input  logic                           last,
    input  logic [icache_pkg::tag_w-1:0]   fill_tag,
    output logic                           hit
);

    logic [`ICB_SETS-1:0]           valid_bits;
    logic                           valid_q;
    logic [icache_pkg::tag_w-1:0]   lookup_tag_q;
    logic [icache_pkg::tag_w-1:0]   stored_tag;

    // Every fill word rewrites the same tag, so a single-word line needs no special case
    sp_ram #(
        .DATAW (icache_pkg::tag_w),
        .SIZE  (`ICB_SETS),
        .WRENW (1),
        .MODE  (icache_pkg::read_first)
    ) u_tag_ram (
        .clk   (clk),
        .reset (reset),
        .read  (read),
        .write (write),
        .wren  (1'b1),
        .addr  (index),
        .wdata (fill_tag),
        .rdata (stored_tag)
    );

    // A line is invalid from its first fill word until its last one lands.
    // When both flags come together the line ends up valid
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
        end else if (write) begin
            if (last) begin
                valid_bits[index] <= 1'b1;
            end else if (first) begin
                valid_bits[index] <= 1'b0;
            end
        end
    end

    // Sample the valid bit alongside the RAM read so both refer to the same lookup
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (read) begin
            valid_q <= valid_bits[index];
        end
    end

    always_ff @(posedge clk) begin
        if (read) begin
            lookup_tag_q <= lookup_tag;
        end
    end

    assign hit = valid_q && (stored_tag == lookup_tag_q);

endmodule

// File: hw/icache_data_store.sv
// Instruction-cache data store: line RAM with word-lane writes and registered word select

`timescale 1ns/1ps

`include "icache_defs.svh"

module icache_data_store (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              read,
    input  logic                              write,
    input  logic [icache_pkg::index_w-1:0]    index,
    input  logic [icache_pkg::word_sel_w-1:0] word_sel,
    input  logic [`ICB_WORD_W-1:0]            wdata,
    output logic [`ICB_WORD_W-1:0]            rdata
);

    logic [`ICB_LINE_WORDS-1:0]        lane_en;
    logic [`ICB_LINE_W-1:0]            line_wdata;
    logic [`ICB_LINE_W-1:0]            line_rdata;
    logic [icache_pkg::word_sel_w-1:0] word_sel_q;

    // One-hot lane enable for the word being filled
    always_comb begin
        lane_en = '0;
        lane_en[word_sel] = 1'b1;
    end

    // Same word on every lane; the enable picks where it lands
    assign line_wdata = {`ICB_LINE_WORDS{wdata}};

    sp_ram #(
        .DATAW (`ICB_LINE_W),
        .SIZE  (`ICB_SETS),
        .WRENW (`ICB_LINE_WORDS),
        .MODE  (icache_pkg::no_change)
    ) u_data_ram (
        .clk   (clk),
        .reset (reset),
        .read  (read),
        .write (write),
        .wren  (lane_en),
        .addr  (index),
        .wdata (line_wdata),
        .rdata (line_rdata)
    );

    // Remember which word the lookup wanted until the line comes out of the RAM
    always_ff @(posedge clk) begin
        if (read) begin
            word_sel_q <= word_sel;
        end
    end

    assign rdata = line_rdata[word_sel_q*`ICB_WORD_W +: `ICB_WORD_W];

endmodule

// File: hw/icache_bank.sv
// Instruction-cache bank top: splits addresses, steers lookups and fills, forms the response

`timescale 1ns/1ps

`include "icache_defs.svh"

module icache_bank (
    input  logic                    clk,
    input  logic                    reset,
    input  icache_pkg::lookup_req_t lookup,
    input  icache_pkg::fill_req_t   fill,
    output icache_pkg::lookup_rsp_t rsp
);

    localparam int sel_lsb = icache_pkg::offset_w;
    localparam int idx_lsb = icache_pkg::offset_w + icache_pkg::word_sel_w;

    logic                              lookup_go;
    logic [icache_pkg::index_w-1:0]    index;
    logic [icache_pkg::word_sel_w-1:0] word_sel;
    logic [icache_pkg::tag_w-1:0]      lookup_tag;
    logic [icache_pkg::tag_w-1:0]      fill_tag;
    logic                              tag_hit;
    logic [`ICB_WORD_W-1:0]            data_word;
    logic                              rsp_valid_q;

    // A fill owns the RAM ports if both strobes show up; the lookup is dropped
    assign lookup_go = lookup.valid && !fill.valid;

    assign index    = fill.valid ? fill.addr[idx_lsb +: icache_pkg::index_w]
                                 : lookup.addr[idx_lsb +: icache_pkg::index_w];
    assign word_sel = fill.valid ? fill.addr[sel_lsb +: icache_pkg::word_sel_w]
                                 : lookup.addr[sel_lsb +: icache_pkg::word_sel_w];

    assign lookup_tag = lookup.addr[`ICB_ADDR_W-1 -: icache_pkg::tag_w];
    assign fill_tag   = fill.addr[`ICB_ADDR_W-1 -: icache_pkg::tag_w];

    icache_tag_store u_tag_store (
        .clk        (clk),
        .reset      (reset),
        .read       (lookup_go),
        .index      (index),
        .lookup_tag (lookup_tag),
        .write      (fill.valid),
        .first      (fill.first),
        .last       (fill.last),
        .fill_tag   (fill_tag),
        .hit        (tag_hit)
    );

    icache_data_store u_data_store (
        .clk      (clk),
        .reset    (reset),
        .read     (lookup_go),
        .write    (fill.valid),
        .index    (index),
        .word_sel (word_sel),
        .wdata    (fill.data),
        .rdata    (data_word)
    );

    // Response comes exactly one cycle after an accepted lookup
    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= lookup_go;
        end
    end

    assign rsp.valid = rsp_valid_q;
    assign rsp.hit   = rsp_valid_q && tag_hit;
    assign rsp.data  = (rsp_valid_q && tag_hit) ? data_word : '0;

endmodule

// File: tests/icache_bank_sva.sv
// Instruction-cache bank assertions: strobe exclusivity, response timing and hit after a fill

`timescale 1ns/1ps

`include "icache_defs.svh"

module icache_bank_sva (
    input logic                    clk,
    input logic                    reset,
    input icache_pkg::lookup_req_t lookup,
    input icache_pkg::fill_req_t   fill,
    input icache_pkg::lookup_rsp_t rsp
);

    localparam int idx_lsb = icache_pkg::offset_w + icache_pkg::word_sel_w;

    logic [`ICB_SETS-1:0]           line_done;
    logic [icache_pkg::tag_w-1:0]   line_tag [`ICB_SETS];
    logic [icache_pkg::index_w-1:0] fill_idx;
    logic [icache_pkg::index_w-1:0] look_idx;
    logic [icache_pkg::tag_w-1:0]   look_tag;

    // Assertion failures seen so far
    int fail_count = 0;

    assign fill_idx = fill.addr[idx_lsb +: icache_pkg::index_w];
    assign look_idx = lookup.addr[idx_lsb +: icache_pkg::index_w];
    assign look_tag = lookup.addr[`ICB_ADDR_W-1 -: icache_pkg::tag_w];

    // A line counts as done once its last word arrived and no new first word followed
    always_ff @(posedge clk) begin
        if (reset) begin
            line_done <= '0;
        end else if (fill.valid) begin
            if (fill.last) begin
                line_done[fill_idx] <= 1'b1;
            end else if (fill.first) begin
                line_done[fill_idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill.valid) begin
            line_tag[fill_idx] <= fill.addr[`ICB_ADDR_W-1 -: icache_pkg::tag_w];
        end
    end

    a_strobe_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(lookup.valid && fill.valid))
        else begin
            $error("lookup and fill strobes were valid in the same cycle");
            fail_count++;
        end

    a_rsp_follows_lookup: assert property (@(posedge clk) disable iff (reset)
        (lookup.valid && !fill.valid) |=> rsp.valid)
        else begin
            $error("no response one cycle after a lookup");
            fail_count++;
        end

    a_no_rsp_without_lookup: assert property (@(posedge clk) disable iff (reset)
        !(lookup.valid && !fill.valid) |=> !rsp.valid)
        else begin
            $error("response appeared without a lookup in the cycle before");
            fail_count++;
        end

    a_hit_after_fill: assert property (@(posedge clk) disable iff (reset)
        (lookup.valid && !fill.valid && line_done[look_idx] && line_tag[look_idx] == look_tag)
        |=> rsp.hit)
        else begin
            $error("lookup to a completed line did not hit");
            fail_count++;
        end

endmodule

// File: tests/icache_bank_tb.sv
// Instruction-cache bank testbench: replays the cases file and checks every lookup response

`timescale 1ns/1ps

`include "icache_defs.svh"

module icache_bank_tb;

    logic                    clk;
    logic                    reset;
    icache_pkg::lookup_req_t lookup;
    icache_pkg::fill_req_t   fill;
    icache_pkg::lookup_rsp_t rsp;

    // One entry per data line of the cases file
    string                  case_name  [$];
    string                  case_op    [$];
    logic [`ICB_ADDR_W-1:0] case_addr  [$];
    logic [`ICB_WORD_W-1:0] case_data  [$];
    logic                   case_first [$];
    logic                   case_last  [$];
    logic                   case_hit   [$];
    logic [`ICB_WORD_W-1:0] case_exp   [$];

    int num_cases;
    int cycle_count = 0;
    int cycle_limit = 0;
    int lookups_checked = 0;

    icache_bank u_icache_bank (
        .clk    (clk),
        .reset  (reset),
        .lookup (lookup),
        .fill   (fill),
        .rsp    (rsp)
    );

    bind icache_bank icache_bank_sva u_sva (
        .clk    (clk),
        .reset  (reset),
        .lookup (lookup),
        .fill   (fill),
        .rsp    (rsp)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // The limit is only armed once the cases are loaded
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run went past %0d cycles without finishing", cycle_limit);
            $display("TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic load_cases();
        int                     fd;
        int                     code;
        bit                     more;
        string                  tok;
        string                  op;
        string                  rest;
        logic [`ICB_ADDR_W-1:0] addr;
        logic [`ICB_WORD_W-1:0] data;
        int                     first;
        int                     last;
        int                     hit;
        logic [`ICB_WORD_W-1:0] exp_data;
        fd = $fopen("tests/icache_bank_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open tests/icache_bank_cases.txt");
            $display("TESTS FAILED");
            $fatal(1, "missing cases file");
        end else begin
            more = 1'b1;
            while (more) begin
                code = $fscanf(fd, "%s", tok);
                if (code != 1) begin
                    more = 1'b0;
                end else if (tok.substr(0, 0) == "#") begin
                    code = $fgets(rest, fd);
                end else begin
                    code = $fscanf(fd, "%s %h %h %d %d %d %h",
                                   op, addr, data, first, last, hit, exp_data);
                    if (code != 7 || !(op == "lookup" || op == "fill" ||
                                       op == "idle" || op == "reset")) begin
                        $display("Cases file line %s is malformed or has an unknown operation",
                                 tok);
                        $display("TESTS FAILED");
                        $fatal(1, "bad cases file");
                    end else begin
                        case_name.push_back(tok);
                        case_op.push_back(op);
                        case_addr.push_back(addr);
                        case_data.push_back(data);
                        case_first.push_back(first != 0);
                        case_last.push_back(last != 0);
                        case_hit.push_back(hit != 0);
                        case_exp.push_back(exp_data);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_idle();
        reset  = 1'b0;
        lookup = '0;
        fill   = '0;
    endtask

    task automatic drive_case(int i);
        drive_idle();
        if (case_op[i] == "reset") begin
            reset = 1'b1;
        end else if (case_op[i] == "lookup") begin
            lookup.valid = 1'b1;
            lookup.addr  = case_addr[i];
        end else if (case_op[i] == "fill") begin
            fill.valid = 1'b1;
            fill.addr  = case_addr[i];
            fill.data  = case_data[i];
            fill.first = case_first[i];
            fill.last  = case_last[i];
        end
    endtask

    // Data only matters when a hit is expected
    task automatic check_lookup(int i);
        logic ok;
        ok = rsp.valid && (rsp.hit == case_hit[i]) && (!case_hit[i] || rsp.data == case_exp[i]);
        lookups_checked++;
        assert (ok) else begin
            $display("FAILED %s: expected valid=1 hit=%0b data=%h, actual valid=%0b hit=%0b data=%h",
                     case_name[i], case_hit[i], case_exp[i], rsp.valid, rsp.hit, rsp.data);
            $display("TESTS FAILED");
            $fatal(1, "lookup response mismatch");
        end
    endtask

    task automatic check_quiet(int i);
        assert (rsp.valid === 1'b0) else begin
            $display("FAILED %s: expected valid=0, actual valid=%0b", case_name[i], rsp.valid);
            $display("TESTS FAILED");
            $fatal(1, "unexpected response");
        end
    endtask

    // The bound checker counts its failures
    task automatic check_assertions();
        assert (u_icache_bank.u_sva.fail_count == 0) else begin
            $display("A bound assertion on the bank failed, see the error above");
            $display("TESTS FAILED");
            $fatal(1, "assertion failure");
        end
    endtask

    initial begin
        reset  = 1'b1;
        lookup = '0;
        fill   = '0;
        load_cases();
        num_cases   = case_op.size();
        cycle_limit = 2 * num_cases + 20;
        repeat (2) @(posedge clk);
        // Each line is driven on a falling edge and its response checked on the next one
        for (int i = 0; i <= num_cases; i++) begin
            @(negedge clk);
            check_assertions();
            if (i > 0) begin
                if (case_op[i-1] == "lookup") begin
                    check_lookup(i - 1);
                end else begin
                    check_quiet(i - 1);
                end
            end
            if (i < num_cases) begin
                drive_case(i);
            end else begin
                drive_idle();
            end
        end
        // One more edge so the assertions started by the last line complete
        @(negedge clk);
        check_assertions();
        if (lookups_checked == 0) begin
            $display("No lookup response was checked, the cases file holds no lookups");
            $display("TESTS FAILED");
            $fatal(1, "empty run");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

// File: build.f
+incdir+hw
hw/icache_pkg.sv
hw/sp_ram.sv
hw/icache_tag_store.sv
hw/icache_data_store.sv
hw/icache_bank.sv
tests/icache_bank_sva.sv
tests/icache_bank_tb.sv

// File: tests/icache_bank_cases.txt
# name op addr fill_data first last exp_hit exp_data (addr and data in hex)
# op is lookup, fill, idle or reset; the expected columns apply to lookups only
cold_set0        lookup 00000000 00000000 0 0 0 00000000
cold_set5        lookup 00000154 00000000 0 0 0 00000000
cold_set15       lookup 000000f8 00000000 0 0 0 00000000
gap_0            idle   00000000 00000000 0 0 0 00000000
fill_a_w0        fill   00001230 11110000 1 0 0 00000000
partial_a_w0     lookup 00001230 00000000 0 0 0 00000000
fill_a_w1        fill   00001234 11110001 0 0 0 00000000
partial_a_w1     lookup 00001234 00000000 0 0 0 00000000
fill_a_w2        fill   00001238 11110002 0 0 0 00000000
fill_a_w3        fill   0000123c 11110003 0 1 0 00000000
hit_a_w0         lookup 00001230 00000000 0 0 1 11110000
hit_a_w1         lookup 00001234 00000000 0 0 1 11110001
hit_a_w2         lookup 00001238 00000000 0 0 1 11110002
hit_a_w3         lookup 0000123c 00000000 0 0 1 11110003
fill_b_single    fill   00005a98 deadbeef 1 1 0 00000000
hit_b_single     lookup 00005a98 00000000 0 0 1 deadbeef
fill_c_w0        fill   00007730 a0a00000 1 0 0 00000000
old_a_during_c   lookup 00001234 00000000 0 0 0 00000000
fill_c_w1        fill   00007734 a0a00001 0 0 0 00000000
fill_c_w2        fill   00007738 a0a00002 0 0 0 00000000
fill_c_w3        fill   0000773c a0a00003 0 1 0 00000000
old_a_miss       lookup 00001230 00000000 0 0 0 00000000
new_c_w1         lookup 00007734 00000000 0 0 1 a0a00001
b2b_set9         lookup 00005a98 00000000 0 0 1 deadbeef
b2b_set0         lookup 00000000 00000000 0 0 0 00000000
b2b_set3         lookup 0000773c 00000000 0 0 1 a0a00003
b2b_set3_w0      lookup 00007730 00000000 0 0 1 a0a00000
gap_1            idle   00000000 00000000 0 0 0 00000000
mid_reset_0      reset  00000000 00000000 0 0 0 00000000
mid_reset_1      reset  00000000 00000000 0 0 0 00000000
after_reset_c    lookup 00007738 00000000 0 0 0 00000000
after_reset_b    lookup 00005a98 00000000 0 0 0 00000000
after_reset_a    lookup 00001230 00000000 0 0 0 00000000
